/* all.f */
hw/src_pkg.sv
hw/src_addr_gen.sv
hw/src_offset_fifo.sv
hw/src_response.sv
hw/src_ctrl.sv
hw/src_streamer_top.sv
tb/tb_clk_gen.sv
tb/src_mem_model.sv
tb/src_asserts.sv
tb/src_tb.sv

/* hw/src_addr_gen.sv */
/*
  Request side of the streamer.
  Walks base + n*stride for tot_len beats after gen_start_i and issues one
  word aligned load per grant; the dropped byte offset goes to the response side.
*/

`timescale 1ns/1ps

module src_addr_gen (
  input  logic              clk_i,
  input  logic              rst_ni,
  input  src_pkg::job_t     job_i,        // held job from the controller
  input  logic              gen_start_i,  // load job, first req next cycle
  input  logic              stream_ready_i,
  output src_pkg::mem_req_t mem_req_o,
  input  logic              mem_gnt_i,
  output logic              issue_o,      // request granted this cycle
  output logic [1:0]        ofs_o,        // byte offset of the granted beat
  output logic              issued_all_o  // level, every beat issued
);

  logic [src_pkg::ADDR_W-1:0] addr_q;      // running byte address
  logic [src_pkg::CNT_W-1:0]  cnt_q;       // beats issued so far
  logic [src_pkg::CNT_W-1:0]  cnt_nxt;
  logic                       active_q;    // beats remain in this job
  logic                       issued_all_q;
  logic [src_pkg::ADDR_W-1:0] stride_ext;

  // stride is unsigned, zero extend to address width
  assign stride_ext = {{(src_pkg::ADDR_W-src_pkg::CNT_W){1'b0}}, job_i.stride};
  assign cnt_nxt    = cnt_q + 1'b1;

  // no new request while the stream is stalled
  assign mem_req_o.req  = active_q & stream_ready_i;
  assign mem_req_o.addr = {addr_q[src_pkg::ADDR_W-1:2], 2'b00}; // word aligned

  assign issue_o      = mem_req_o.req & mem_gnt_i;
  assign ofs_o        = addr_q[1:0]; // realign select for this beat
  assign issued_all_o = issued_all_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      addr_q       <= '0;
      cnt_q        <= '0;
      active_q     <= 1'b0;
      issued_all_q <= 1'b0;
    end else if (gen_start_i) begin
      // fresh job, counters from zero
      addr_q       <= job_i.base_addr;
      cnt_q        <= '0;
      active_q     <= 1'b1;
      issued_all_q <= 1'b0;
    end else if (issue_o) begin
      addr_q <= addr_q + stride_ext; // addr only moves on a grant
      cnt_q  <= cnt_nxt;
      if (cnt_nxt == job_i.tot_len) begin
        active_q     <= 1'b0; // last beat out
        issued_all_q <= 1'b1;
      end
    end
  end

endmodule

/* hw/src_ctrl.sv */
/*
  Job controller of the streamer.
  Latches a job on start, kicks the address generator, then waits for
  all requests issued and all beats delivered before pulsing done.
  ready_o is high only in IDLE, so one job runs at a time.
*/

`timescale 1ns/1ps

module src_ctrl (
  input  logic                      clk_i,
  input  logic                      rst_ni,
  input  logic                      start_i,      // job strobe
  input  src_pkg::job_t             job_i,
  input  logic                      issued_all_i, // from the request side
  input  logic [src_pkg::CNT_W-1:0] beats_i,      // from the response side
  output src_pkg::job_t             job_o,        // held job
  output logic                      gen_start_o,
  output logic                      cnt_clr_o,
  output logic                      ready_o,
  output logic                      done_o
);

  src_pkg::src_state_e state_q, state_d;
  src_pkg::job_t       job_q;
  logic                accept;
  logic                all_beats; // every beat left the stream

  assign accept    = start_i & ready_o; // start while busy is dropped
  assign all_beats = (beats_i == job_q.tot_len);

  // held job, loaded on accept
  always_ff @(posedge clk_i) begin
    if (accept) job_q <= job_i;
  end

  assign job_o = job_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) state_q <= src_pkg::SRC_IDLE;
    else         state_q <= state_d;
  end

  always_comb begin
    state_d     = state_q;
    gen_start_o = 1'b0;
    cnt_clr_o   = 1'b0;
    done_o      = 1'b0;
    ready_o     = 1'b0;
    case (state_q)
      src_pkg::SRC_IDLE: begin
        ready_o = 1'b1;
        if (start_i) state_d = src_pkg::SRC_PRESAMPLE;
      end
      src_pkg::SRC_PRESAMPLE: begin
        gen_start_o = 1'b1; // addr gen loads job_q
        state_d     = src_pkg::SRC_WORKING;
      end
      src_pkg::SRC_WORKING: begin
        if (issued_all_i) state_d = src_pkg::SRC_DONE;
      end
      src_pkg::SRC_DONE: begin
        // responses may still be in flight
        if (all_beats) begin
          done_o    = 1'b1;
          cnt_clr_o = 1'b1;
          state_d   = src_pkg::SRC_IDLE;
        end
      end
      default: state_d = src_pkg::SRC_IDLE;
    endcase
  end

endmodule

/* hw/src_offset_fifo.sv */
/*
  Small circular FIFO of 2-bit byte offsets.
  Pushed on every granted load, popped on every stream transfer.
  Head is read combinationally; no back-pressure towards the pusher.
*/

`timescale 1ns/1ps

module src_offset_fifo #(
  parameter int unsigned DEPTH = 8 // must cover outstanding loads
) (
  input  logic       clk_i,
  input  logic       rst_ni,
  input  logic       push_i,
  input  logic [1:0] data_i,
  input  logic       pop_i,
  output logic [1:0] data_o,  // head entry
  output logic       empty_o,
  output logic       full_o
);

  localparam int unsigned PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int unsigned OCC_W = $clog2(DEPTH + 1);

  logic [1:0]       mem_q [DEPTH];
  logic [PTR_W-1:0] wr_ptr_q, rd_ptr_q;
  logic [OCC_W-1:0] occ_q;   // entries held
  logic             do_push, do_pop;

  assign empty_o = (occ_q == '0);
  assign full_o  = (occ_q == OCC_W'(DEPTH));
  assign data_o  = mem_q[rd_ptr_q];

  // overflow and underflow leave the state untouched
  assign do_push = push_i & ~full_o;
  assign do_pop  = pop_i & ~empty_o;

  always_ff @(posedge clk_i) begin
    if (do_push) mem_q[wr_ptr_q] <= data_i;
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      occ_q    <= '0;
    end else begin
      if (do_push) wr_ptr_q <= (wr_ptr_q == PTR_W'(DEPTH-1)) ? '0 : wr_ptr_q + 1'b1;
      if (do_pop)  rd_ptr_q <= (rd_ptr_q == PTR_W'(DEPTH-1)) ? '0 : rd_ptr_q + 1'b1;
      if (do_push & ~do_pop)      occ_q <= occ_q + 1'b1;
      else if (do_pop & ~do_push) occ_q <= occ_q - 1'b1;
    end
  end

endmodule

/* hw/src_pkg.sv */
/*
  Shared types and widths for the memory-to-stream source streamer.
  Job descriptor, memory request bundle and controller states.
  Referenced by scoped name from every RTL and testbench file.
*/

package src_pkg;

  // byte address width on the memory port
  localparam int unsigned ADDR_W = 32;
  // beat counter and stride width
  localparam int unsigned CNT_W  = 16;

  // one job as handed in on start_i, 64 bits
  typedef struct packed {
    logic [ADDR_W-1:0] base_addr; // first beat byte address
    logic [CNT_W-1:0]  stride;    // unsigned byte step between beats
    logic [CNT_W-1:0]  tot_len;   // beats in the job, at least 1
  } job_t;

  // load request towards memory, 33 bits
  typedef struct packed {
    logic              req;  // request valid, paired with gnt
    logic [ADDR_W-1:0] addr; // word aligned byte address
  } mem_req_t;

  // job controller states
  typedef enum logic [1:0] {
    SRC_IDLE      = 2'd0, // waiting for start
    SRC_PRESAMPLE = 2'd1, // address generator loads the job
    SRC_WORKING   = 2'd2, // requests going out
    SRC_DONE      = 2'd3  // all issued, draining responses
  } src_state_e;

endpackage

/* hw/src_response.sv */
/*
  Response side of the streamer.
  Cuts each memory response (one word wider than the stream) down to a
  stream beat, using the byte offset queued when the load was granted,
  and counts transferred beats for the controller.
*/

`timescale 1ns/1ps

module src_response #(
  parameter int unsigned STREAM_DW = 32, // multiple of 32
  parameter int unsigned OFS_DEPTH = 8
) (
  input  logic                      clk_i,
  input  logic                      rst_ni,
  input  logic                      issue_i,   // load granted
  input  logic [1:0]                ofs_i,     // its byte offset
  input  logic                      cnt_clr_i, // end of job
  input  logic                      mem_r_valid_i,
  input  logic [STREAM_DW+32-1:0]   mem_r_data_i,
  output logic                      mem_r_ready_o,
  output logic                      stream_valid_o,
  output logic [STREAM_DW-1:0]      stream_data_o,
  input  logic                      stream_ready_i,
  output logic [src_pkg::CNT_W-1:0] beats_o
);

  localparam int unsigned MEM_DW = STREAM_DW + 32;

  logic [1:0]                ofs_head;  // offset of the oldest load
  logic                      ofs_empty; // fifo status, seen by the checker
  logic                      ofs_full;
  logic                      xfer;      // beat accepted downstream
  logic [src_pkg::CNT_W-1:0] beats_q;

  // responses come back in order, so head offset matches the response
  src_offset_fifo #(
    .DEPTH   ( OFS_DEPTH )
  ) i_ofs_fifo (
    .clk_i   ( clk_i     ),
    .rst_ni  ( rst_ni    ),
    .push_i  ( issue_i   ),
    .data_i  ( ofs_i     ),
    .pop_i   ( xfer      ),
    .data_o  ( ofs_head  ),
    .empty_o ( ofs_empty ),
    .full_o  ( ofs_full  )
  );

  // memory holds its response while the stream stalls
  assign mem_r_ready_o  = stream_ready_i;
  assign stream_valid_o = mem_r_valid_i;
  assign xfer           = stream_valid_o & stream_ready_i;

  // pick bytes k .. k+STREAM_DW/8-1 of the wide response
  always_comb begin
    stream_data_o = mem_r_data_i[STREAM_DW-1:0];
    case (ofs_head)
      2'd0: stream_data_o = mem_r_data_i[STREAM_DW-1:0];
      2'd1: stream_data_o = mem_r_data_i[STREAM_DW+7:8];
      2'd2: stream_data_o = mem_r_data_i[STREAM_DW+15:16];
      2'd3: stream_data_o = mem_r_data_i[MEM_DW-9:24]; // top byte unused
      default: ;
    endcase
  end

  // delivered beat count, one cycle behind the transfer
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni)        beats_q <= '0;
    else if (cnt_clr_i) beats_q <= '0;
    else if (xfer)      beats_q <= beats_q + 1'b1;
  end

  assign beats_o = beats_q;

endmodule

/* hw/src_streamer_top.sv */
/*
  Top of the memory-to-stream source streamer.
  Takes one job (base, stride, length), loads it word by word over a
  req/gnt memory port and emits realigned beats on a valid/ready stream.
*/

`timescale 1ns/1ps

module src_streamer_top #(
  parameter int unsigned STREAM_DW = 32, // stream width, multiple of 32
  parameter int unsigned OFS_DEPTH = 8   // max outstanding loads
) (
  input  logic                    clk_i,
  input  logic                    rst_ni,
  // job
  input  logic                    start_i,
  input  src_pkg::job_t           job_i,
  output logic                    ready_o,
  output logic                    done_o,
  // memory port
  output src_pkg::mem_req_t       mem_req_o,
  input  logic                    mem_gnt_i,
  input  logic                    mem_r_valid_i,
  input  logic [STREAM_DW+32-1:0] mem_r_data_i,
  output logic                    mem_r_ready_o,
  // output stream
  output logic                    stream_valid_o,
  output logic [STREAM_DW-1:0]    stream_data_o,
  input  logic                    stream_ready_i
);

  src_pkg::job_t             job_q;
  logic                      gen_start, cnt_clr;
  logic                      issue, issued_all;
  logic [1:0]                ofs;
  logic [src_pkg::CNT_W-1:0] beats;

  src_ctrl i_ctrl (
    .clk_i, .rst_ni,
    .start_i,
    .job_i,
    .issued_all_i ( issued_all ),
    .beats_i      ( beats      ),
    .job_o        ( job_q      ),
    .gen_start_o  ( gen_start  ),
    .cnt_clr_o    ( cnt_clr    ),
    .ready_o,
    .done_o
  );

  src_addr_gen i_addr_gen (
    .clk_i, .rst_ni,
    .job_i        ( job_q      ),
    .gen_start_i  ( gen_start  ),
    .stream_ready_i,
    .mem_req_o,
    .mem_gnt_i,
    .issue_o      ( issue      ),
    .ofs_o        ( ofs        ),
    .issued_all_o ( issued_all )
  );

  src_response #(
    .STREAM_DW ( STREAM_DW ),
    .OFS_DEPTH ( OFS_DEPTH )
  ) i_response (
    .clk_i, .rst_ni,
    .issue_i   ( issue   ),
    .ofs_i     ( ofs     ),
    .cnt_clr_i ( cnt_clr ),
    .mem_r_valid_i, .mem_r_data_i, .mem_r_ready_o,
    .stream_valid_o, .stream_data_o, .stream_ready_i,
    .beats_o   ( beats   )
  );

endmodule

/* run.sh */
#!/usr/bin/env bash
# Build and run the streamer testbench with Verilator.
set -e
cd "$(dirname "$0")"

rm -rf obj_dir sim.log
verilator --binary --timing --assert -j 0 --top-module src_tb -f all.f

# the run may stop on $fatal; the log decides
./obj_dir/Vsrc_tb > sim.log 2>&1 || true
cat sim.log

if grep -q "Simulation passed" sim.log; then
  exit 0
else
  exit 1
fi

/* tb/src_asserts.sv */
/*
  Concurrent checks on the memory port and the offset FIFO.
  Bound into the streamer top.
*/

`timescale 1ns/1ps

module src_asserts (
  input logic                       clk_i,
  input logic                       rst_ni,
  input logic                       push_i,  // load granted
  input logic                       pop_i,   // beat transferred
  input logic                       full_i,
  input logic                       empty_i,
  input logic                       req_i,
  input logic                       gnt_i,
  input logic [src_pkg::ADDR_W-1:0] addr_i
);

  no_push_full: assert property (@(posedge clk_i) disable iff (!rst_ni) !(push_i && full_i))
    else $error("offset FIFO pushed while full");

  no_pop_empty: assert property (@(posedge clk_i) disable iff (!rst_ni) !(pop_i && empty_i))
    else $error("offset FIFO popped while empty");

  // waiting request keeps its address
  addr_stable: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (req_i && !gnt_i) |=> $stable(addr_i))
    else $error("request address moved while waiting for grant");

  addr_aligned: assert property (@(posedge clk_i) disable iff (!rst_ni)
    req_i |-> (addr_i[1:0] == 2'b00))
    else $error("request address not word aligned");

endmodule

bind src_streamer_top src_asserts asserts_i (
  .clk_i   ( clk_i                  ),
  .rst_ni  ( rst_ni                 ),
  .push_i  ( issue                  ),
  .pop_i   ( i_response.xfer        ),
  .full_i  ( i_response.ofs_full    ),
  .empty_i ( i_response.ofs_empty   ),
  .req_i   ( mem_req_o.req          ),
  .gnt_i   ( mem_gnt_i              ),
  .addr_i  ( mem_req_o.addr         )
);

/* tb/src_mem_model.sv */
/*
  Memory model for the streamer testbench.
  Random grants, 1..4 cycle in-order responses, and a response is held
  until r_ready. Byte A reads as A[7:0] ^ 8'h5a.
*/

`timescale 1ns/1ps

module src_mem_model #(
  parameter int unsigned STREAM_DW = 32,
  parameter int unsigned DEPTH     = 8 // max loads in flight
) (
  input  logic                    clk_i,
  input  logic                    rst_ni,
  input  src_pkg::mem_req_t       mem_req_i,
  output logic                    mem_gnt_o,
  output logic                    r_valid_o,
  output logic [STREAM_DW+32-1:0] r_data_o,
  input  logic                    r_ready_i
);

  localparam int unsigned MEM_DW = STREAM_DW + 32;

  integer                     seed = 32'h691ed3b6;
  logic [src_pkg::ADDR_W-1:0] addr_mem [16]; // in-flight word addresses
  int                         due_mem  [16]; // cycle the response shows up
  logic [3:0]                 wr_q, rd_q;
  int                         cnt_q;         // loads granted, not yet returned
  int                         cyc_q;
  logic                       gnt_rand_q;

  // bytes W .. W+MEM_DW/8-1, lowest address in the lowest byte
  function automatic logic [MEM_DW-1:0] word_bytes(input logic [src_pkg::ADDR_W-1:0] w);
    logic [MEM_DW-1:0]          d;
    logic [src_pkg::ADDR_W-1:0] a;
    for (int i = 0; i < MEM_DW / 8; i++) begin
      a          = w + i;
      d[8*i +: 8] = a[7:0] ^ 8'h5a;
    end
    return d;
  endfunction

  assign mem_gnt_o = gnt_rand_q && (cnt_q < DEPTH); // never past the offset FIFO depth
  assign r_valid_o = (cnt_q > 0) && (cyc_q >= due_mem[rd_q]);
  assign r_data_o  = word_bytes(addr_mem[rd_q]);

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wr_q       <= '0;
      rd_q       <= '0;
      cnt_q      <= 0;
      cyc_q      <= 0;
      gnt_rand_q <= 1'b0;
    end else begin
      cyc_q      <= cyc_q + 1;
      gnt_rand_q <= $random(seed) & 1;
      if (mem_req_i.req && mem_gnt_o) begin
        addr_mem[wr_q] <= mem_req_i.addr;
        due_mem[wr_q]  <= cyc_q + 1 + ($random(seed) & 3); // 1..4 cycles
        wr_q           <= wr_q + 1'b1;
      end
      if (r_valid_o && r_ready_i) rd_q <= rd_q + 1'b1;
      cnt_q <= cnt_q + ((mem_req_i.req && mem_gnt_o) ? 1 : 0)
                     - ((r_valid_o && r_ready_i) ? 1 : 0);
    end
  end

endmodule

/* tb/src_tb.sv */
/*
  Testbench top for the source streamer.
  Directed job tests against a random-latency memory model; a monitor
  compares every stream beat with bytes computed from the job.
*/

`timescale 1ns/1ps

module src_tb;

  localparam int unsigned STREAM_DW = 32;
  localparam int          MAX_CYC   = 20000; // 89 beats plus job overhead, far below this

  logic                    clk, rst_n;
  logic                    start_i, ready_o, done_o;
  src_pkg::job_t           job_i;
  src_pkg::mem_req_t       mem_req;
  logic                    mem_gnt, mem_r_valid, mem_r_ready;
  logic [STREAM_DW+31:0]   mem_r_data;
  logic                    stream_valid, stream_ready;
  logic [STREAM_DW-1:0]    stream_data;

  integer                  seed = 32'h691ed3b6;
  logic [STREAM_DW-1:0]    exp_q[$]; // beats still to come
  int                      done_cnt = 0;
  int                      cyc = 0;
  logic                    bp_en = 1'b0;

  tb_clk_gen #(.PERIOD(40ns), .RST_CYCLES(4)) clk_gen_i (.clk_o(clk), .rst_no(rst_n));

  src_streamer_top dut_i (
    .clk_i          ( clk          ),
    .rst_ni         ( rst_n        ),
    .start_i        ( start_i      ),
    .job_i          ( job_i        ),
    .ready_o        ( ready_o      ),
    .done_o         ( done_o       ),
    .mem_req_o      ( mem_req      ),
    .mem_gnt_i      ( mem_gnt      ),
    .mem_r_valid_i  ( mem_r_valid  ),
    .mem_r_data_i   ( mem_r_data   ),
    .mem_r_ready_o  ( mem_r_ready  ),
    .stream_valid_o ( stream_valid ),
    .stream_data_o  ( stream_data  ),
    .stream_ready_i ( stream_ready )
  );

  src_mem_model #(.STREAM_DW(STREAM_DW), .DEPTH(8)) mem_i (
    .clk_i     ( clk         ),
    .rst_ni    ( rst_n       ),
    .mem_req_i ( mem_req     ),
    .mem_gnt_o ( mem_gnt     ),
    .r_valid_o ( mem_r_valid ),
    .r_data_o  ( mem_r_data  ),
    .r_ready_i ( mem_r_ready )
  );

  task automatic stop_with_failure(input string msg);
    $display("%s", msg);
    $display("Simulation failed");
    $fatal(1);
  endtask

  // bytes at a .. a+3 with the lowest address in the low byte
  function automatic logic [STREAM_DW-1:0] expected_beat(input logic [31:0] a);
    logic [STREAM_DW-1:0] d;
    logic [31:0]          b;
    for (int i = 0; i < STREAM_DW / 8; i++) begin
      b          = a + i;
      d[8*i +: 8] = b[7:0] ^ 8'h5a;
    end
    return d;
  endfunction

  // stall pattern for the stream side
  always @(posedge clk) begin
    if (bp_en) stream_ready <= $random(seed) & 1;
    else       stream_ready <= 1'b1;
  end

  // scoreboard and done monitor
  always @(posedge clk) begin
    if (rst_n && stream_valid && stream_ready) begin
      assert (exp_q.size() > 0)
        else stop_with_failure("stream beat delivered with no beat expected");
      assert (stream_data == exp_q[0])
        else stop_with_failure($sformatf("Error: stream_data_o expected %h actual %h",
                                         exp_q[0], stream_data));
      void'(exp_q.pop_front());
    end
    if (rst_n && done_o) begin
      assert (exp_q.size() == 0)
        else stop_with_failure("done pulsed before the last beat was transferred");
      done_cnt <= done_cnt + 1;
    end
  end

  always @(posedge clk) begin
    cyc <= cyc + 1;
    if (cyc >= MAX_CYC) stop_with_failure("timeout, a job never finished");
  end

  // called on a rising edge with ready_o high and returns on the edge after done
  task automatic run_job(input logic [31:0] base, input logic [15:0] stride,
                         input logic [15:0] len, input bit busy_start);
    int  done_before;
    bit  first;
    done_before = done_cnt;
    first       = 1'b1;
    for (int n = 0; n < len; n++) exp_q.push_back(expected_beat(base + n * stride));
    start_i <= 1'b1;
    job_i   <= '{base_addr: base, stride: stride, tot_len: len};
    @(posedge clk);
    start_i <= 1'b0;
    job_i   <= '0;
    forever begin
      @(posedge clk);
      assert (ready_o == 1'b0)
        else stop_with_failure($sformatf("Error: ready_o expected %h actual %h", 1'b0, ready_o));
      if (done_o) break;
      if (busy_start && first) begin
        start_i <= 1'b1; // must be dropped
        job_i   <= '{base_addr: 32'h9000, stride: 16'd4, tot_len: 16'd3};
      end else begin
        start_i <= 1'b0;
      end
      first = 1'b0;
    end
    start_i <= 1'b0;
    @(posedge clk);
    assert (ready_o == 1'b1)
      else stop_with_failure($sformatf("Error: ready_o expected %h actual %h", 1'b1, ready_o));
    assert (done_o == 1'b0)
      else stop_with_failure($sformatf("Error: done_o expected %h actual %h", 1'b0, done_o));
    assert (done_cnt == done_before + 1)
      else stop_with_failure($sformatf("Error: done_o pulses expected %h actual %h",
                                       done_before + 1, done_cnt));
  endtask

  task automatic reset_then_aligned_job();
    assert (ready_o == 1'b1 && done_o == 1'b0 && mem_req.req == 1'b0 && stream_valid == 1'b0)
      else stop_with_failure($sformatf("Error: ready/done/req/valid expected %h actual %h",
                                       4'b1000, {ready_o, done_o, mem_req.req, stream_valid}));
    run_job(32'h100, 16'd4, 16'd8, 1'b0);
  endtask

  task automatic misaligned_jobs();
    run_job(32'h201, 16'd4, 16'd6, 1'b0);
    run_job(32'h302, 16'd4, 16'd6, 1'b0);
    run_job(32'h403, 16'd4, 16'd6, 1'b0);
    run_job(32'h501, 16'd5, 16'd10, 1'b0); // offset changes every beat
  endtask

  task automatic backpressured_job();
    bp_en <= 1'b1;
    run_job(32'h1003, 16'd7, 16'd40, 1'b0);
    bp_en <= 1'b0;
  endtask

  task automatic busy_start_ignored();
    run_job(32'h800, 16'd4, 16'd5, 1'b1);
  endtask

  task automatic back_to_back_jobs();
    run_job(32'h2002, 16'd3, 16'd3, 1'b0);
    run_job(32'h3001, 16'd4, 16'd1, 1'b0); // single beat
    run_job(32'h4000, 16'd9, 16'd4, 1'b0);
  endtask

  initial begin
    start_i      = 1'b0;
    job_i        = '0;
    stream_ready = 1'b1;
    @(posedge rst_n);
    @(posedge clk);
    reset_then_aligned_job();
    misaligned_jobs();
    backpressured_job();
    busy_start_ignored();
    back_to_back_jobs();
    if (exp_q.size() == 0) begin
      $display("Simulation passed");
    end else begin
      $display("beats left over at end of run");
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

/* tb/tb_clk_gen.sv */
/*
  Testbench clock and reset source.
  Free running clock, reset held low for a few rising edges at start.
*/

`timescale 1ns/1ps

module tb_clk_gen #(
  parameter realtime PERIOD     = 40ns,
  parameter int      RST_CYCLES = 4
) (
  output logic clk_o,
  output logic rst_no
);

  initial begin
    clk_o  = 1'b0;
    rst_no = 1'b0;
    repeat (RST_CYCLES) @(posedge clk_o);
    rst_no <= 1'b1; // release on a rising edge
  end

  always #(PERIOD / 2) clk_o = ~clk_o;

endmodule
